/* verilog/mci_cfg.svh */
`ifndef MCI_CFG_SVH
`define MCI_CFG_SVH

//////////////////////////////
// Widths
//////////////////////////////

// Register data and word address
`define MCI_DATA_W    32
`define MCI_ADDR_W    6

// Each aggregated subsystem error vector
`define MCI_AGG_ERR_W 32

//////////////////////////////
// Register word addresses
//////////////////////////////

// Boot control
`define MCI_ADDR_BOOT_GO             6'd0
`define MCI_ADDR_BOOT_STATUS         6'd1

// Watchdog timer 1
`define MCI_ADDR_WDT_T1_EN           6'd2
`define MCI_ADDR_WDT_T1_CTRL         6'd3
`define MCI_ADDR_WDT_T1_PERIOD       6'd4

// Watchdog timer 2
`define MCI_ADDR_WDT_T2_EN           6'd5
`define MCI_ADDR_WDT_T2_CTRL         6'd6
`define MCI_ADDR_WDT_T2_PERIOD       6'd7

// Timeout flags, write 1 to clear
`define MCI_ADDR_WDT_STATUS          6'd8

// Error aggregation
`define MCI_ADDR_ERR_FATAL           6'd9
`define MCI_ADDR_ERR_NON_FATAL       6'd10
`define MCI_ADDR_ERR_FATAL_MASK      6'd11
`define MCI_ADDR_ERR_NON_FATAL_MASK  6'd12

// Reset value of both timer periods
`define MCI_WDT_PERIOD_RST           32'hFFFF_FFFF

`endif

/* verilog/mci_pkg.sv */
`include "mci_cfg.svh"

package mci_pkg;

    //////////////////////////////
    // Register port
    //////////////////////////////

    // Single-cycle strobe request
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`MCI_ADDR_W-1:0] addr;
        logic [`MCI_DATA_W-1:0] wdata;
    } mci_reg_req_t;

    // Response, one cycle after the request
    typedef struct packed {
        logic                   valid;
        logic                   error;
        logic [`MCI_DATA_W-1:0] rdata;
    } mci_reg_rsp_t;

    //////////////////////////////
    // Watchdog
    //////////////////////////////

    typedef struct packed {
        logic                   t1_en;
        logic                   t2_en;
        // Single-cycle pulses
        logic                   t1_restart;
        logic                   t2_restart;
        logic                   t1_clear;
        logic                   t2_clear;
        logic [`MCI_DATA_W-1:0] t1_period;
        logic [`MCI_DATA_W-1:0] t2_period;
    } mci_wdt_ctrl_t;

    typedef struct packed {
        logic t1_timeout;
        logic t2_timeout;
    } mci_wdt_status_t;

    //////////////////////////////
    // Boot sequencer
    //////////////////////////////

    typedef struct packed {
        logic bootfsm_go;
        logic caliptra_go;
    } mci_boot_ctrl_t;

    typedef enum logic [2:0] {
        BOOT_IDLE    = 3'd0,
        BOOT_LCC     = 3'd1,
        BOOT_FC      = 3'd2,
        BOOT_MCU_RUN = 3'd3,
        BOOT_DONE    = 3'd4
    } mci_boot_state_e;

endpackage

/* verilog/mci_reg_block.sv */
`include "mci_cfg.svh"

module mci_reg_block
    import mci_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n_i,

    input  mci_reg_req_t              reg_req_i,
    output mci_reg_rsp_t              reg_rsp_o,

    input  logic [`MCI_AGG_ERR_W-1:0] agg_error_fatal_i,
    input  logic [`MCI_AGG_ERR_W-1:0] agg_error_non_fatal_i,

    input  mci_wdt_status_t           wdt_status_i,
    input  mci_boot_state_e           boot_state_i,
    output mci_wdt_ctrl_t             wdt_ctrl_o,
    output mci_boot_ctrl_t            boot_ctrl_o,

    output logic                      all_error_fatal_o,
    output logic                      all_error_non_fatal_o
);

    logic                      wr_sel;
    logic                      addr_hit;
    logic                      bad_access;
    logic [`MCI_DATA_W-1:0]    rd_data;

    mci_boot_ctrl_t            boot_ctrl_q;
    logic                      t1_en_q;
    logic                      t2_en_q;
    logic [`MCI_DATA_W-1:0]    t1_period_q;
    logic [`MCI_DATA_W-1:0]    t2_period_q;

    logic [`MCI_AGG_ERR_W-1:0] fatal_sts_q;
    logic [`MCI_AGG_ERR_W-1:0] non_fatal_sts_q;
    logic [`MCI_AGG_ERR_W-1:0] fatal_mask_q;
    logic [`MCI_AGG_ERR_W-1:0] non_fatal_mask_q;
    logic [`MCI_AGG_ERR_W-1:0] fatal_clr;
    logic [`MCI_AGG_ERR_W-1:0] non_fatal_clr;
    logic                      all_fatal_q;
    logic                      all_non_fatal_q;

    mci_reg_rsp_t              rsp_q;

    //////////////////////////////
    // Decode and read mux
    //////////////////////////////

    assign wr_sel = reg_req_i.valid && reg_req_i.write;

    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (reg_req_i.addr)
            `MCI_ADDR_BOOT_GO:            rd_data[1:0] = {boot_ctrl_q.caliptra_go,
                                                          boot_ctrl_q.bootfsm_go};
            `MCI_ADDR_BOOT_STATUS:        rd_data[2:0] = boot_state_i;
            `MCI_ADDR_WDT_T1_EN:          rd_data[0]   = t1_en_q;
            `MCI_ADDR_WDT_T1_PERIOD:      rd_data      = t1_period_q;
            `MCI_ADDR_WDT_T2_EN:          rd_data[0]   = t2_en_q;
            `MCI_ADDR_WDT_T2_PERIOD:      rd_data      = t2_period_q;
            `MCI_ADDR_WDT_STATUS:         rd_data[1:0] = {wdt_status_i.t2_timeout,
                                                          wdt_status_i.t1_timeout};
            `MCI_ADDR_ERR_FATAL:          rd_data      = fatal_sts_q;
            `MCI_ADDR_ERR_NON_FATAL:      rd_data      = non_fatal_sts_q;
            `MCI_ADDR_ERR_FATAL_MASK:     rd_data      = fatal_mask_q;
            `MCI_ADDR_ERR_NON_FATAL_MASK: rd_data      = non_fatal_mask_q;
            // Restart bits are pulses, nothing to read back
            `MCI_ADDR_WDT_T1_CTRL,
            `MCI_ADDR_WDT_T2_CTRL:        rd_data      = '0;
            default:                      addr_hit     = 1'b0;
        endcase
    end

    // Status is read-only
    assign bad_access = !addr_hit ||
                        (reg_req_i.write && reg_req_i.addr == `MCI_ADDR_BOOT_STATUS);

    //////////////////////////////
    // Control registers
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            boot_ctrl_q      <= '0;
            t1_en_q          <= 1'b0;
            t2_en_q          <= 1'b0;
            t1_period_q      <= `MCI_WDT_PERIOD_RST;
            t2_period_q      <= `MCI_WDT_PERIOD_RST;
            fatal_mask_q     <= '0;
            non_fatal_mask_q <= '0;
        end else if (wr_sel) begin
            case (reg_req_i.addr)
                `MCI_ADDR_BOOT_GO: begin
                    boot_ctrl_q.bootfsm_go  <= reg_req_i.wdata[0];
                    boot_ctrl_q.caliptra_go <= reg_req_i.wdata[1];
                end
                `MCI_ADDR_WDT_T1_EN:          t1_en_q          <= reg_req_i.wdata[0];
                `MCI_ADDR_WDT_T1_PERIOD:      t1_period_q      <= reg_req_i.wdata;
                `MCI_ADDR_WDT_T2_EN:          t2_en_q          <= reg_req_i.wdata[0];
                `MCI_ADDR_WDT_T2_PERIOD:      t2_period_q      <= reg_req_i.wdata;
                `MCI_ADDR_ERR_FATAL_MASK:
                    fatal_mask_q <= reg_req_i.wdata[`MCI_AGG_ERR_W-1:0];
                `MCI_ADDR_ERR_NON_FATAL_MASK:
                    non_fatal_mask_q <= reg_req_i.wdata[`MCI_AGG_ERR_W-1:0];
                default: ;
            endcase
        end
    end

    // Watchdog pulses act on the request edge
    always_comb begin
        wdt_ctrl_o.t1_en      = t1_en_q;
        wdt_ctrl_o.t2_en      = t2_en_q;
        wdt_ctrl_o.t1_restart = wr_sel && reg_req_i.addr == `MCI_ADDR_WDT_T1_CTRL &&
                                reg_req_i.wdata[0];
        wdt_ctrl_o.t2_restart = wr_sel && reg_req_i.addr == `MCI_ADDR_WDT_T2_CTRL &&
                                reg_req_i.wdata[0];
        wdt_ctrl_o.t1_clear   = wr_sel && reg_req_i.addr == `MCI_ADDR_WDT_STATUS &&
                                reg_req_i.wdata[0];
        wdt_ctrl_o.t2_clear   = wr_sel && reg_req_i.addr == `MCI_ADDR_WDT_STATUS &&
                                reg_req_i.wdata[1];
        wdt_ctrl_o.t1_period  = t1_period_q;
        wdt_ctrl_o.t2_period  = t2_period_q;
    end

    assign boot_ctrl_o = boot_ctrl_q;

    //////////////////////////////
    // Error aggregation
    //////////////////////////////

    assign fatal_clr     = (wr_sel && reg_req_i.addr == `MCI_ADDR_ERR_FATAL) ?
                           reg_req_i.wdata[`MCI_AGG_ERR_W-1:0] : '0;
    assign non_fatal_clr = (wr_sel && reg_req_i.addr == `MCI_ADDR_ERR_NON_FATAL) ?
                           reg_req_i.wdata[`MCI_AGG_ERR_W-1:0] : '0;

    // New error wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fatal_sts_q     <= '0;
            non_fatal_sts_q <= '0;
            all_fatal_q     <= 1'b0;
            all_non_fatal_q <= 1'b0;
        end else begin
            fatal_sts_q     <= (fatal_sts_q & ~fatal_clr) | agg_error_fatal_i;
            non_fatal_sts_q <= (non_fatal_sts_q & ~non_fatal_clr) | agg_error_non_fatal_i;
            all_fatal_q     <= |(fatal_sts_q & ~fatal_mask_q);
            all_non_fatal_q <= |(non_fatal_sts_q & ~non_fatal_mask_q);
        end
    end

    assign all_error_fatal_o     = all_fatal_q;
    assign all_error_non_fatal_o = all_non_fatal_q;

    //////////////////////////////
    // Response
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.valid <= reg_req_i.valid;
            rsp_q.error <= reg_req_i.valid && bad_access;
            rsp_q.rdata <= (reg_req_i.valid && !reg_req_i.write && !bad_access) ?
                           rd_data : '0;
        end
    end

    assign reg_rsp_o = rsp_q;

endmodule

/* verilog/mci_wdt.sv */
`include "mci_cfg.svh"

module mci_wdt
    import mci_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,

    input  mci_wdt_ctrl_t   wdt_ctrl_i,
    output mci_wdt_status_t wdt_status_o,

    output logic            mcu_timer_int_o,
    output logic            nmi_intr_o
);

    // Index 0 is timer 1, index 1 is timer 2
    logic [1:0]                  restart;
    logic [1:0]                  clear;
    logic [1:0]                  run;
    logic [1:0][`MCI_DATA_W-1:0] period;
    logic [1:0][`MCI_DATA_W-1:0] cnt_q;
    logic [1:0]                  flag_q;

    assign restart = {wdt_ctrl_i.t2_restart, wdt_ctrl_i.t1_restart};
    assign clear   = {wdt_ctrl_i.t2_clear,   wdt_ctrl_i.t1_clear};
    assign period  = {wdt_ctrl_i.t2_period,  wdt_ctrl_i.t1_period};

    //////////////////////////////
    // Run conditions
    //////////////////////////////

    assign run[0] = wdt_ctrl_i.t1_en;

    // Cascade when t2_en is low
    // Timer 2 then waits for the first stage to expire
    assign run[1] = wdt_ctrl_i.t2_en || (flag_q[0] && !flag_q[1]);

    //////////////////////////////
    // Counters and sticky flags
    //////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            flag_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!run[i] || restart[i] || clear[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_q[i] != period[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end

                // Counter holds at the period once it expires
                if (clear[i]) begin
                    flag_q[i] <= 1'b0;
                end else if (run[i] && !restart[i] && cnt_q[i] == period[i]) begin
                    flag_q[i] <= 1'b1;
                end
            end
        end
    end

    assign wdt_status_o.t1_timeout = flag_q[0];
    assign wdt_status_o.t2_timeout = flag_q[1];

    // First stage interrupts the MCU, second stage is fatal
    assign mcu_timer_int_o = flag_q[0];
    assign nmi_intr_o      = flag_q[1];

endmodule

/* verilog/mci_boot_seqr.sv */
`include "mci_cfg.svh"

module mci_boot_seqr
    import mci_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,

    input  mci_boot_ctrl_t  boot_ctrl_i,

    // Lifecycle and fuse controller handshake
    input  logic            lc_done_i,
    input  logic            fc_opt_done_i,
    output logic            lc_init_o,
    output logic            fc_opt_init_o,

    // Reset releases
    output logic            mcu_rst_b_o,
    output logic            cptra_rst_b_o,

    output mci_boot_state_e boot_state_o
);

    mci_boot_state_e state_q;
    mci_boot_state_e state_d;
    logic            lc_init_q;
    logic            fc_opt_init_q;
    logic            mcu_rst_b_q;
    logic            cptra_rst_b_q;

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            BOOT_IDLE:    if (boot_ctrl_i.bootfsm_go)  state_d = BOOT_LCC;
            BOOT_LCC:     if (lc_done_i)               state_d = BOOT_FC;
            BOOT_FC:      if (fc_opt_done_i)           state_d = BOOT_MCU_RUN;
            BOOT_MCU_RUN: if (boot_ctrl_i.caliptra_go) state_d = BOOT_DONE;
            // Done holds until reset
            BOOT_DONE:                                 state_d = BOOT_DONE;
            default:                                   state_d = BOOT_IDLE;
        endcase
    end

    //////////////////////////////
    // State and decoded outputs
    //////////////////////////////

    // Outputs decode the next state so they line up with state_q
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q       <= BOOT_IDLE;
            lc_init_q     <= 1'b0;
            fc_opt_init_q <= 1'b0;
            mcu_rst_b_q   <= 1'b0;
            cptra_rst_b_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            lc_init_q     <= (state_d == BOOT_LCC);
            fc_opt_init_q <= (state_d == BOOT_FC);
            mcu_rst_b_q   <= (state_d == BOOT_MCU_RUN) || (state_d == BOOT_DONE);
            cptra_rst_b_q <= (state_d == BOOT_DONE);
        end
    end

    assign lc_init_o     = lc_init_q;
    assign fc_opt_init_o = fc_opt_init_q;
    assign mcu_rst_b_o   = mcu_rst_b_q;
    assign cptra_rst_b_o = cptra_rst_b_q;
    assign boot_state_o  = state_q;

endmodule

/* verilog/mci_top.sv */
`include "mci_cfg.svh"

module mci_top
    import mci_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n_i,

    // Register port
    input  mci_reg_req_t              reg_req_i,
    output mci_reg_rsp_t              reg_rsp_o,

    // Subsystem errors
    input  logic [`MCI_AGG_ERR_W-1:0] agg_error_fatal_i,
    input  logic [`MCI_AGG_ERR_W-1:0] agg_error_non_fatal_i,

    // Lifecycle and fuse controllers
    input  logic                      lc_done_i,
    input  logic                      fc_opt_done_i,
    output logic                      lc_init_o,
    output logic                      fc_opt_init_o,

    // Reset controls
    output logic                      mcu_rst_b_o,
    output logic                      cptra_rst_b_o,

    // Interrupts
    output logic                      mcu_timer_int_o,
    output logic                      nmi_intr_o,
    output logic                      all_error_fatal_o,
    output logic                      all_error_non_fatal_o
);

    mci_wdt_ctrl_t   wdt_ctrl;
    mci_wdt_status_t wdt_status;
    mci_boot_ctrl_t  boot_ctrl;
    mci_boot_state_e boot_state;

    //////////////////////////////
    // CSR bank
    //////////////////////////////

    mci_reg_block i_mci_reg_block (
        .clk                   (clk),
        .arst_n_i              (arst_n_i),
        .reg_req_i             (reg_req_i),
        .reg_rsp_o             (reg_rsp_o),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .wdt_status_i          (wdt_status),
        .boot_state_i          (boot_state),
        .wdt_ctrl_o            (wdt_ctrl),
        .boot_ctrl_o           (boot_ctrl),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o)
    );

    // Two-stage watchdog
    mci_wdt i_mci_wdt (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .wdt_ctrl_i      (wdt_ctrl),
        .wdt_status_o    (wdt_status),
        .mcu_timer_int_o (mcu_timer_int_o),
        .nmi_intr_o      (nmi_intr_o)
    );

    // Boot sequencer
    mci_boot_seqr i_boot_seqr (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .boot_ctrl_i   (boot_ctrl),
        .lc_done_i     (lc_done_i),
        .fc_opt_done_i (fc_opt_done_i),
        .lc_init_o     (lc_init_o),
        .fc_opt_init_o (fc_opt_init_o),
        .mcu_rst_b_o   (mcu_rst_b_o),
        .cptra_rst_b_o (cptra_rst_b_o),
        .boot_state_o  (boot_state)
    );

endmodule

/* testbench/mci_top_checker.sv */
`include "mci_cfg.svh"

module mci_top_checker
    import mci_pkg::*;
(
    input logic         clk,
    input logic         arst_n_i,
    input mci_reg_req_t reg_req_i,
    input mci_reg_rsp_t reg_rsp_o,
    input logic         nmi_intr_o,
    input logic         lc_init_o,
    input logic         fc_opt_init_o,
    input logic         mcu_rst_b_o,
    input logic         cptra_rst_b_o
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////
    // Register port
    //////////////////////////////

    rsp_follows_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        reg_req_i.valid |=> reg_rsp_o.valid)
        else $error("response missing one cycle after a request");

    no_rsp_without_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        !reg_req_i.valid |=> !reg_rsp_o.valid)
        else $error("response without a request");

    //////////////////////////////
    // Watchdog and boot
    //////////////////////////////

    // NMI only drops on a t2 clear write
    nmi_sticky: assert property (@(posedge clk) disable iff (!arst_n_i)
        $fell(nmi_intr_o) |-> $past(reg_req_i.valid && reg_req_i.write &&
                                    reg_req_i.addr == `MCI_ADDR_WDT_STATUS &&
                                    reg_req_i.wdata[1]))
        else $error("NMI fell without a clear write");

    init_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(lc_init_o && fc_opt_init_o))
        else $error("lifecycle and fuse init high together");

    rst_order: assert property (@(posedge clk) disable iff (!arst_n_i)
        cptra_rst_b_o |-> mcu_rst_b_o)
        else $error("Caliptra reset released before MCU reset");

endmodule

bind mci_top mci_top_checker i_mci_top_checker (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .reg_req_i     (reg_req_i),
    .reg_rsp_o     (reg_rsp_o),
    .nmi_intr_o    (nmi_intr_o),
    .lc_init_o     (lc_init_o),
    .fc_opt_init_o (fc_opt_init_o),
    .mcu_rst_b_o   (mcu_rst_b_o),
    .cptra_rst_b_o (cptra_rst_b_o)
);

/* testbench/tb_mci_top.sv */
`include "mci_cfg.svh"

module tb_mci_top
    import mci_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Rough sum of all test lengths in cycles
    localparam int TEST_CYCLES    = 500;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

    logic                      clk;
    logic                      arst_n;
    mci_reg_req_t              req;
    mci_reg_rsp_t              rsp;
    logic [`MCI_AGG_ERR_W-1:0] fatal_in;
    logic [`MCI_AGG_ERR_W-1:0] non_fatal_in;
    logic                      lc_done;
    logic                      fc_done;
    logic                      lc_init;
    logic                      fc_init;
    logic                      mcu_rst_b;
    logic                      cptra_rst_b;
    logic                      timer_int;
    logic                      nmi;
    logic                      all_fatal;
    logic                      all_non_fatal;

    integer                    seed = 19;
    int                        checks;
    int                        errors;
    int                        cycle_cnt;

    // Reference model state
    logic [`MCI_DATA_W-1:0]    model_reg [0:15];
    logic [`MCI_AGG_ERR_W-1:0] model_fatal;
    logic [`MCI_AGG_ERR_W-1:0] model_non_fatal;

    mci_top uut (
        .clk                   (clk),
        .arst_n_i              (arst_n),
        .reg_req_i             (req),
        .reg_rsp_o             (rsp),
        .agg_error_fatal_i     (fatal_in),
        .agg_error_non_fatal_i (non_fatal_in),
        .lc_done_i             (lc_done),
        .fc_opt_done_i         (fc_done),
        .lc_init_o             (lc_init),
        .fc_opt_init_o         (fc_init),
        .mcu_rst_b_o           (mcu_rst_b),
        .cptra_rst_b_o         (cptra_rst_b),
        .mcu_timer_int_o       (timer_int),
        .nmi_intr_o            (nmi),
        .all_error_fatal_o     (all_fatal),
        .all_error_non_fatal_o (all_non_fatal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("** Error at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    // Request on one edge, response sampled at the following negedge
    task automatic reg_access(input bit wr, input logic [5:0] addr,
                              input logic [31:0] wdata, output mci_reg_rsp_t r);
        @(posedge clk);
        req <= {1'b1, wr, addr, wdata};
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        r = rsp;
        check(r.valid, $sformatf("no response to the access at %0d", addr));
    endtask

    task automatic reg_write(input logic [5:0] addr, input logic [31:0] wdata);
        mci_reg_rsp_t r;
        reg_access(1'b1, addr, wdata, r);
        check(!r.error && r.rdata == '0,
              $sformatf("write to %0d flagged error or returned data", addr));
    endtask

    task automatic reg_check(input logic [5:0] addr, input logic [31:0] exp);
        mci_reg_rsp_t r;
        reg_access(1'b0, addr, '0, r);
        check(!r.error && r.rdata == exp,
              $sformatf("read %0d: got %h, expected %h", addr, r.rdata, exp));
    endtask

    function automatic bit out_bit(input int which);
        case (which)
            0: return timer_int;
            1: return nmi;
            2: return lc_init;
            3: return fc_init;
            4: return mcu_rst_b;
            default: return cptra_rst_b;
        endcase
    endfunction

    // Count negedges until an output is high, up to a limit
    task automatic wait_high(input int which, input int limit, output int cycles);
        cycles = 0;
        while (cycles < limit && !out_bit(which)) begin
            @(negedge clk);
            cycles++;
        end
        check(out_bit(which), $sformatf("output %0d not high after %0d cycles", which, limit));
    endtask

    function automatic int rand_range(input int lo, input int span);
        return lo + ($unsigned($random(seed)) % span);
    endfunction

    task automatic end_test(input string name, input int err0);
        $display("Test %s finished with %0d errors", name, errors - err0);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_registers();
        int            err0;
        logic [5:0]    addr;
        logic [31:0]   data;
        logic [5:0]    rw_addrs [6];
        mci_reg_rsp_t  r;
        err0 = errors;
        rw_addrs = '{`MCI_ADDR_WDT_T1_EN, `MCI_ADDR_WDT_T1_PERIOD, `MCI_ADDR_WDT_T2_EN,
                     `MCI_ADDR_WDT_T2_PERIOD, `MCI_ADDR_ERR_FATAL_MASK,
                     `MCI_ADDR_ERR_NON_FATAL_MASK};
        for (int i = 0; i < 20; i++) begin
            addr = rw_addrs[rand_range(0, 6)];
            data = $random(seed);
            // Enables keep only bit 0
            if (addr == `MCI_ADDR_WDT_T1_EN || addr == `MCI_ADDR_WDT_T2_EN)
                model_reg[addr] = {31'd0, data[0]};
            else
                model_reg[addr] = data;
            reg_write(addr, data);
            reg_check(addr, model_reg[addr]);
        end
        for (int i = 0; i < 10; i++) begin
            addr = rand_range(13, 51);
            reg_access(i[0], addr, $random(seed), r);
            check(r.error && r.rdata == '0, $sformatf("unmapped %0d not flagged", addr));
        end
        reg_access(1'b1, `MCI_ADDR_BOOT_STATUS, 32'h7, r);
        check(r.error && r.rdata == '0, "write to BOOT_STATUS not flagged");
        reg_check(`MCI_ADDR_BOOT_STATUS, 32'd0);
        // Leave both timers off
        reg_write(`MCI_ADDR_WDT_T1_EN, 32'd0);
        reg_write(`MCI_ADDR_WDT_T2_EN, 32'd0);
        end_test("register access", err0);
    endtask

    task automatic test_errors();
        int          err0;
        logic [31:0] pf;
        logic [31:0] pn;
        logic [31:0] fm;
        logic [31:0] nm;
        logic [31:0] clr;
        err0 = errors;
        for (int i = 0; i < 12; i++) begin
            pf = $random(seed) & $random(seed) & $random(seed);
            pn = $random(seed) & $random(seed) & $random(seed);
            @(posedge clk);
            fatal_in     <= pf;
            non_fatal_in <= pn;
            @(posedge clk);
            fatal_in     <= '0;
            non_fatal_in <= '0;
            model_fatal     = model_fatal | pf;
            model_non_fatal = model_non_fatal | pn;
            fm = $random(seed) | $random(seed);
            nm = $random(seed) | $random(seed);
            reg_write(`MCI_ADDR_ERR_FATAL_MASK, fm);
            reg_write(`MCI_ADDR_ERR_NON_FATAL_MASK, nm);
            if (i % 3 == 2) begin
                clr = $random(seed);
                reg_write(`MCI_ADDR_ERR_FATAL, clr);
                model_fatal = model_fatal & ~clr;
                clr = $random(seed);
                reg_write(`MCI_ADDR_ERR_NON_FATAL, clr);
                model_non_fatal = model_non_fatal & ~clr;
            end
            reg_check(`MCI_ADDR_ERR_FATAL, model_fatal);
            reg_check(`MCI_ADDR_ERR_NON_FATAL, model_non_fatal);
            check(all_fatal == |(model_fatal & ~fm), "all_error_fatal_o mismatch");
            check(all_non_fatal == |(model_non_fatal & ~nm), "all_error_non_fatal_o mismatch");
        end
        end_test("error aggregation", err0);
    endtask

    task automatic test_timer1();
        int err0;
        int p;
        int n;
        err0 = errors;
        p = rand_range(4, 16);
        reg_write(`MCI_ADDR_WDT_T1_PERIOD, p);
        reg_write(`MCI_ADDR_WDT_T1_EN, 32'd1);
        wait_high(0, p + 3, n);
        check(n >= p, $sformatf("timer 1 expired after %0d cycles, period %0d", n, p));
        reg_check(`MCI_ADDR_WDT_STATUS, 32'd1);
        reg_write(`MCI_ADDR_WDT_STATUS, 32'd1);
        check(!timer_int, "timer 1 flag not cleared");
        // Restart halfway must push the timeout out
        repeat (p / 2) @(negedge clk);
        reg_write(`MCI_ADDR_WDT_T1_CTRL, 32'd1);
        check(!timer_int, "timer 1 flag set before restart expired");
        wait_high(0, p + 3, n);
        check(n >= p, $sformatf("restarted timer 1 expired after %0d cycles", n));
        reg_write(`MCI_ADDR_WDT_T1_EN, 32'd0);
        reg_write(`MCI_ADDR_WDT_STATUS, 32'd1);
        check(!timer_int, "timer 1 flag not cleared at end");
        end_test("watchdog timer 1", err0);
    endtask

    task automatic test_cascade();
        int err0;
        int p;
        int q;
        int n;
        err0 = errors;
        p = rand_range(4, 12);
        q = rand_range(4, 12);
        reg_write(`MCI_ADDR_WDT_T1_PERIOD, p);
        reg_write(`MCI_ADDR_WDT_T2_PERIOD, q);
        reg_write(`MCI_ADDR_WDT_T1_EN, 32'd1);
        wait_high(1, p + q + 6, n);
        check(n >= p + q, $sformatf("cascade NMI after %0d cycles, periods %0d+%0d", n, p, q));
        reg_check(`MCI_ADDR_WDT_STATUS, 32'd3);
        reg_write(`MCI_ADDR_WDT_T1_EN, 32'd0);
        reg_write(`MCI_ADDR_WDT_STATUS, 32'd3);
        check(!nmi && !timer_int, "watchdog flags not cleared after cascade");
        // Independent mode
        q = rand_range(4, 12);
        reg_write(`MCI_ADDR_WDT_T2_PERIOD, q);
        reg_write(`MCI_ADDR_WDT_T2_EN, 32'd1);
        wait_high(1, q + 3, n);
        check(n >= q, $sformatf("independent NMI after %0d cycles, period %0d", n, q));
        check(!timer_int, "timer 1 flag set in independent mode");
        reg_write(`MCI_ADDR_WDT_T2_EN, 32'd0);
        reg_write(`MCI_ADDR_WDT_STATUS, 32'd2);
        check(!nmi, "NMI not cleared");
        end_test("cascade and NMI", err0);
    endtask

    task automatic test_boot();
        int err0;
        int n;
        err0 = errors;
        check(!lc_init && !mcu_rst_b && !cptra_rst_b, "boot outputs active before go");
        reg_write(`MCI_ADDR_BOOT_GO, 32'd1);
        wait_high(2, 10, n);
        reg_check(`MCI_ADDR_BOOT_STATUS, BOOT_LCC);
        reg_check(`MCI_ADDR_BOOT_GO, 32'd1);
        check(lc_init && !fc_init && !mcu_rst_b, "outputs wrong in lifecycle init");
        repeat (rand_range(1, 8)) @(posedge clk);
        lc_done <= 1'b1;
        wait_high(3, 10, n);
        check(!lc_init && !mcu_rst_b, "lifecycle init or MCU reset wrong in fuse init");
        @(posedge clk);
        lc_done <= 1'b0;
        reg_check(`MCI_ADDR_BOOT_STATUS, BOOT_FC);
        check(fc_init && !lc_init, "fuse init dropped before done");
        repeat (rand_range(1, 8)) @(posedge clk);
        fc_done <= 1'b1;
        wait_high(4, 10, n);
        @(posedge clk);
        fc_done <= 1'b0;
        check(!fc_init, "fuse init still high after MCU reset release");
        reg_check(`MCI_ADDR_BOOT_STATUS, BOOT_MCU_RUN);
        repeat (5) begin
            @(negedge clk);
            check(!cptra_rst_b, "Caliptra reset released before go");
        end
        reg_write(`MCI_ADDR_BOOT_GO, 32'd3);
        wait_high(5, 10, n);
        reg_check(`MCI_ADDR_BOOT_STATUS, BOOT_DONE);
        check(mcu_rst_b, "MCU reset not held released in BOOT_DONE");
        end_test("boot sequence", err0);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        arst_n       = 1'b0;
        req          = '0;
        fatal_in     = '0;
        non_fatal_in = '0;
        lc_done      = 1'b0;
        fc_done      = 1'b0;
        checks       = 0;
        errors       = 0;
        model_fatal     = '0;
        model_non_fatal = '0;
        for (int i = 0; i < 16; i++) model_reg[i] = '0;
        model_reg[`MCI_ADDR_WDT_T1_PERIOD] = `MCI_WDT_PERIOD_RST;
        model_reg[`MCI_ADDR_WDT_T2_PERIOD] = `MCI_WDT_PERIOD_RST;

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check(!rsp.valid && !lc_init && !fc_init && !mcu_rst_b && !cptra_rst_b &&
              !nmi && !timer_int && !all_fatal && !all_non_fatal,
              "outputs not low after reset");

        test_registers();
        test_errors();
        test_timer1();
        test_cascade();
        test_boot();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
verilog/mci_pkg.sv
verilog/mci_reg_block.sv
verilog/mci_wdt.sv
verilog/mci_boot_seqr.sv
verilog/mci_top.sv
testbench/mci_top_checker.sv
testbench/tb_mci_top.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module tb_mci_top \
    -f sources.f -o sim_mci_top || exit 1

out=$(./obj_dir/sim_mci_top)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
